//--- design/ecfg_regmap_pkg.sv
/*
 configuration page register map
 register index enum, memory interface field widths, page select constant
*/
`default_nettype none

package ecfg_regmap_pkg;

   // ##############################
   // memory interface geometry
   // ##############################
   localparam int MI_AW    = 20;              // physical address, no shifting
   localparam int MI_DW    = 32;              // word writes only
   localparam int RFAW     = 5;               // index taken from addr[RFAW+1:2]
   localparam int PAGE_LSB = 12;              // page field sits above the 4k offset
   localparam int PAGE_W   = MI_AW - PAGE_LSB;

   // addr[19:12] must match this to reach the config space
   localparam logic [PAGE_W-1:0] ECFG_PAGE = 8'hF0;

   // ##############################
   // register indices
   // ##############################
   typedef enum logic [RFAW-1:0] {
      EL_VERSION = 5'd0,                      // read only
      EL_COREID  = 5'd1,
      EL_CLKDIV  = 5'd2,
      EL_RESET   = 5'd3,                      // sw reset level
      EL_TX      = 5'd4,
      EL_DATAOUT = 5'd5,
      EL_TXDEBUG = 5'd6,
      EL_RX      = 5'd8,                      // 7 left as a hole
      EL_DATAIN  = 5'd9,
      EL_RXDEBUG = 5'd10
   } ecfg_reg_e;                              // anything else reads zero

endpackage

`default_nettype wire

//--- design/elink_cfg_pkg.sv
/*
 link configuration field definitions
 pin mode enum, register field widths, reset values
*/
`default_nettype none

package elink_cfg_pkg;

   // pin mode field, shared by tx and rx control
   typedef enum logic [1:0] {
      MODE_NORMAL  = 2'd0,
      MODE_GPIO    = 2'd1,                    // pins driven from data regs
      MODE_TESTPAT = 2'd2,                    // tx clock pattern, rx loopback
      MODE_RSVD    = 2'd3
   } link_mode_e;

   // ##############################
   // field widths
   // ##############################
   localparam int CTRLMODE_W = 4;             // emesh ctrlmode tag
   localparam int PIN_W      = 9;             // elink pin data
   localparam int DEBUG_W    = 16;            // per-direction debug bus
   localparam int STICKY_W   = 3;             // low debug bits held sticky
   localparam int VERSION_W  = 16;
   localparam int COREID_W   = 12;
   localparam int CLKDIV_W   = 4;
   localparam int TXCTRL_W   = 4 + CTRLMODE_W + 1;   // en, mmu, mode, ctrlmode, bp
   localparam int RXCTRL_W   = 4;                    // en, mmu, mode

   // ##############################
   // reset values
   // ##############################
   localparam logic [VERSION_W-1:0] DEFAULT_VERSION = 16'h0102;
   localparam logic [COREID_W-1:0]  DEFAULT_COREID  = 12'h808;
   localparam logic [CLKDIV_W-1:0]  DEFAULT_CLKDIV  = 4'd7;

endpackage

`default_nettype wire

//--- design/ecfg_page_decode.sv
/*
 configuration page decoder
 page match qualifies the access strobe, group read buses are ORed onto mi_dout
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_page_decode (
   input  wire                                     mi_clk,
   input  wire                                     reset,
   input  wire                                     mi_en,
   input  wire                                     mi_we,
   input  wire  [ecfg_regmap_pkg::PAGE_W-1:0]      mi_addr,    // addr[19:12] only
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       base_dout,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       tx_dout,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       rx_dout,
   output logic                                    cfg_en,
   output logic [ecfg_regmap_pkg::MI_DW-1:0]       mi_dout
);
   import ecfg_regmap_pkg::*;

   logic page_hit;
   logic dout_live;                           // a group read has landed since reset

   // ##############################
   // page qualify
   // ##############################
   assign page_hit = (mi_addr == ECFG_PAGE);
   assign cfg_en   = mi_en & page_hit;        // groups never look at the page

   // group douts load only on reads, so they are undefined until the
   // first page read; keep the bus at zero until then
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         dout_live <= 1'b0;
      end else if (cfg_en && !mi_we) begin
         dout_live <= 1'b1;                   // every group loads on this edge
      end
   end

   // ##############################
   // readback combine
   // ##############################
   // each group zeroes indices it does not own, so a plain OR is exact
   always_comb begin
      if (dout_live) begin
         mi_dout = base_dout | tx_dout | rx_dout;
      end else begin
         mi_dout = '0;
      end
   end

endmodule

`default_nettype wire

//--- design/ecfg_base.sv
/*
 base register group
 version, core id, clock divider and software reset level, with readback
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_base (
   input  wire                                     mi_clk,
   input  wire                                     reset,
   input  wire                                     cfg_en,     // page-qualified strobe
   input  wire                                     mi_we,
   input  wire  [ecfg_regmap_pkg::RFAW-1:0]        reg_idx,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       mi_din,
   output logic [ecfg_regmap_pkg::MI_DW-1:0]       base_dout,
   output logic [elink_cfg_pkg::COREID_W-1:0]      ecfg_coreid,
   output logic [elink_cfg_pkg::CLKDIV_W-1:0]      ecfg_clkdiv,
   output logic                                    ecfg_sw_reset
);
   import ecfg_regmap_pkg::*;
   import elink_cfg_pkg::*;

   logic cfg_write;
   logic cfg_read;

   assign cfg_write = cfg_en & mi_we;
   assign cfg_read  = cfg_en & ~mi_we;

   // ##############################
   // writable registers
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         ecfg_coreid <= DEFAULT_COREID;       // mesh coordinate after hard reset
      end else if (cfg_write && reg_idx == EL_COREID) begin
         ecfg_coreid <= mi_din[COREID_W-1:0];
      end
   end

   always_ff @(posedge mi_clk) begin
      if (reset) begin
         ecfg_clkdiv <= DEFAULT_CLKDIV;       // slowest link clock
      end else if (cfg_write && reg_idx == EL_CLKDIV) begin
         ecfg_clkdiv <= mi_din[CLKDIV_W-1:0];
      end
   end

   // level, not a pulse; software must clear it again
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         ecfg_sw_reset <= 1'b0;
      end else if (cfg_write && reg_idx == EL_RESET) begin
         ecfg_sw_reset <= mi_din[0];
      end
   end

   // ##############################
   // readback
   // ##############################
   // registered on the read strobe, held otherwise
   always_ff @(posedge mi_clk) begin
      if (cfg_read) begin
         case (reg_idx)
            EL_VERSION: base_dout <= {{(MI_DW-VERSION_W){1'b0}}, DEFAULT_VERSION};
            EL_COREID:  base_dout <= {{(MI_DW-COREID_W){1'b0}}, ecfg_coreid};
            EL_CLKDIV:  base_dout <= {{(MI_DW-CLKDIV_W){1'b0}}, ecfg_clkdiv};
            EL_RESET:   base_dout <= {{(MI_DW-1){1'b0}}, ecfg_sw_reset};
            default:    base_dout <= '0;           // not ours, keep the OR clean
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/ecfg_tx.sv
/*
 transmit register group
 tx control with mode decode, direct output data, sticky tx debug flags
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_tx (
   input  wire                                     mi_clk,
   input  wire                                     reset,
   input  wire                                     cfg_en,
   input  wire                                     mi_we,
   input  wire  [ecfg_regmap_pkg::RFAW-1:0]        reg_idx,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       mi_din,
   input  wire  [elink_cfg_pkg::DEBUG_W-1:0]       ecfg_tx_debug,
   output logic [ecfg_regmap_pkg::MI_DW-1:0]       tx_dout,
   output logic                                    ecfg_tx_enable,
   output logic                                    ecfg_tx_mmu_enable,
   output logic                                    ecfg_tx_gpio_enable,   // pins from dataout
   output logic                                    ecfg_tx_tp_enable,     // clock test pattern
   output logic [elink_cfg_pkg::CTRLMODE_W-1:0]    ecfg_tx_ctrlmode,
   output logic                                    ecfg_tx_ctrlmode_bp,
   output logic [elink_cfg_pkg::PIN_W-1:0]         ecfg_dataout
);
   import ecfg_regmap_pkg::*;
   import elink_cfg_pkg::*;

   logic                cfg_write;
   logic                cfg_read;
   logic [TXCTRL_W-1:0] tx_reg;               // [0] en [1] mmu [3:2] mode [7:4] ctrlmode [8] bp
   logic [STICKY_W-1:0] debug_sticky;
   link_mode_e          tx_mode;

   assign cfg_write = cfg_en & mi_we;
   assign cfg_read  = cfg_en & ~mi_we;

   // ##############################
   // tx control
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         tx_reg <= '0;                        // disabled, normal mode
      end else if (cfg_write && reg_idx == EL_TX) begin
         tx_reg <= mi_din[TXCTRL_W-1:0];
      end
   end

   assign tx_mode             = link_mode_e'(tx_reg[3:2]);
   assign ecfg_tx_enable      = tx_reg[0];
   assign ecfg_tx_mmu_enable  = tx_reg[1];
   assign ecfg_tx_gpio_enable = (tx_mode == MODE_GPIO);
   assign ecfg_tx_tp_enable   = (tx_mode == MODE_TESTPAT);
   assign ecfg_tx_ctrlmode    = tx_reg[4 +: CTRLMODE_W];
   assign ecfg_tx_ctrlmode_bp = tx_reg[TXCTRL_W-1];   // top bit

   // ##############################
   // direct output data
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         ecfg_dataout <= '0;
      end else if (cfg_write && reg_idx == EL_DATAOUT) begin
         ecfg_dataout <= mi_din[PIN_W-1:0];
      end
   end

   // sticky low debug bits, only hard reset clears them
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         debug_sticky <= '0;
      end else begin
         debug_sticky <= debug_sticky | ecfg_tx_debug[STICKY_W-1:0];
      end
   end

   // ##############################
   // readback
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (cfg_read) begin
         case (reg_idx)
            EL_TX:      tx_dout <= {{(MI_DW-TXCTRL_W){1'b0}}, tx_reg};
            EL_DATAOUT: tx_dout <= {{(MI_DW-PIN_W){1'b0}}, ecfg_dataout};
            EL_TXDEBUG: tx_dout <= {{(MI_DW-DEBUG_W){1'b0}},
                                    ecfg_tx_debug[DEBUG_W-1:STICKY_W],  // live
                                    debug_sticky};
            default:    tx_dout <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/ecfg_rx.sv
/*
 receive register group
 rx control with mode decode, input pin synchronizer, sticky rx debug flags
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_rx (
   input  wire                                     mi_clk,
   input  wire                                     reset,
   input  wire                                     cfg_en,
   input  wire                                     mi_we,
   input  wire  [ecfg_regmap_pkg::RFAW-1:0]        reg_idx,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       mi_din,
   input  wire  [elink_cfg_pkg::DEBUG_W-1:0]       ecfg_rx_debug,
   input  wire  [elink_cfg_pkg::PIN_W-1:0]         ecfg_datain,   // async pins
   output logic [ecfg_regmap_pkg::MI_DW-1:0]       rx_dout,
   output logic                                    ecfg_rx_enable,
   output logic                                    ecfg_rx_mmu_enable,
   output logic                                    ecfg_rx_gpio_enable,
   output logic                                    ecfg_rx_loopback
);
   import ecfg_regmap_pkg::*;
   import elink_cfg_pkg::*;

   logic                cfg_write;
   logic                cfg_read;
   logic [RXCTRL_W-1:0] rx_reg;               // [0] en [1] mmu [3:2] mode
   logic [STICKY_W-1:0] debug_sticky;
   logic [PIN_W-1:0]    datain_meta;          // first sync stage
   logic [PIN_W-1:0]    datain_sync;
   link_mode_e          rx_mode;

   assign cfg_write = cfg_en & mi_we;
   assign cfg_read  = cfg_en & ~mi_we;

   // ##############################
   // rx control
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (reset) begin
         rx_reg <= '0;
      end else if (cfg_write && reg_idx == EL_RX) begin
         rx_reg <= mi_din[RXCTRL_W-1:0];
      end
   end

   assign rx_mode             = link_mode_e'(rx_reg[3:2]);
   assign ecfg_rx_enable      = rx_reg[0];
   assign ecfg_rx_mmu_enable  = rx_reg[1];
   assign ecfg_rx_gpio_enable = (rx_mode == MODE_GPIO);
   assign ecfg_rx_loopback    = (rx_mode == MODE_TESTPAT);  // test pattern means loopback on rx

   // two flops, value readable once it has been stable for three cycles
   always_ff @(posedge mi_clk) begin
      datain_meta <= ecfg_datain;
      datain_sync <= datain_meta;
   end

   always_ff @(posedge mi_clk) begin
      if (reset) begin
         debug_sticky <= '0;
      end else begin
         debug_sticky <= debug_sticky | ecfg_rx_debug[STICKY_W-1:0];  // set only
      end
   end

   // ##############################
   // readback
   // ##############################
   always_ff @(posedge mi_clk) begin
      if (cfg_read) begin
         case (reg_idx)
            EL_RX:      rx_dout <= {{(MI_DW-RXCTRL_W){1'b0}}, rx_reg};
            EL_DATAIN:  rx_dout <= {{(MI_DW-PIN_W){1'b0}}, datain_sync};
            EL_RXDEBUG: rx_dout <= {{(MI_DW-DEBUG_W){1'b0}},
                                    ecfg_rx_debug[DEBUG_W-1:STICKY_W],
                                    debug_sticky};
            default:    rx_dout <= '0;         // outside rx group
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/ecfg_elink.sv
/*
 elink configuration register file top
 page decoder plus base, tx and rx register groups
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_elink (
   input  wire                                     mi_clk,
   input  wire                                     reset,
   input  wire                                     mi_en,
   input  wire                                     mi_we,
   input  wire  [ecfg_regmap_pkg::MI_AW-1:0]       mi_addr,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       mi_din,
   output logic [ecfg_regmap_pkg::MI_DW-1:0]       mi_dout,
   // base
   output logic [elink_cfg_pkg::COREID_W-1:0]      ecfg_coreid,
   output logic [elink_cfg_pkg::CLKDIV_W-1:0]      ecfg_clkdiv,
   output logic                                    ecfg_sw_reset,
   // tx
   input  wire  [elink_cfg_pkg::DEBUG_W-1:0]       ecfg_tx_debug,
   output logic                                    ecfg_tx_enable,
   output logic                                    ecfg_tx_mmu_enable,
   output logic                                    ecfg_tx_gpio_enable,
   output logic                                    ecfg_tx_tp_enable,
   output logic [elink_cfg_pkg::CTRLMODE_W-1:0]    ecfg_tx_ctrlmode,
   output logic                                    ecfg_tx_ctrlmode_bp,
   output logic [elink_cfg_pkg::PIN_W-1:0]         ecfg_dataout,
   // rx
   input  wire  [elink_cfg_pkg::DEBUG_W-1:0]       ecfg_rx_debug,
   input  wire  [elink_cfg_pkg::PIN_W-1:0]         ecfg_datain,
   output logic                                    ecfg_rx_enable,
   output logic                                    ecfg_rx_mmu_enable,
   output logic                                    ecfg_rx_gpio_enable,
   output logic                                    ecfg_rx_loopback
);
   import ecfg_regmap_pkg::*;

   logic             cfg_en;                  // page-qualified mi_en
   logic [RFAW-1:0]  reg_idx;
   logic [MI_DW-1:0] base_dout;
   logic [MI_DW-1:0] tx_dout;
   logic [MI_DW-1:0] rx_dout;

   assign reg_idx = mi_addr[RFAW+1:2];        // word index, byte bits dropped

   ecfg_page_decode i_page_decode (
      .mi_clk    (mi_clk),
      .reset     (reset),
      .mi_en     (mi_en),
      .mi_we     (mi_we),
      .mi_addr   (mi_addr[MI_AW-1:PAGE_LSB]),
      .base_dout (base_dout),
      .tx_dout   (tx_dout),
      .rx_dout   (rx_dout),
      .cfg_en    (cfg_en),
      .mi_dout   (mi_dout)
   );

   ecfg_base i_base (
      .mi_clk        (mi_clk),
      .reset         (reset),
      .cfg_en        (cfg_en),
      .mi_we         (mi_we),
      .reg_idx       (reg_idx),
      .mi_din        (mi_din),
      .base_dout     (base_dout),
      .ecfg_coreid   (ecfg_coreid),
      .ecfg_clkdiv   (ecfg_clkdiv),
      .ecfg_sw_reset (ecfg_sw_reset)
   );

   ecfg_tx i_tx (
      .mi_clk              (mi_clk),
      .reset               (reset),
      .cfg_en              (cfg_en),
      .mi_we               (mi_we),
      .reg_idx             (reg_idx),
      .mi_din              (mi_din),
      .ecfg_tx_debug       (ecfg_tx_debug),
      .tx_dout             (tx_dout),
      .ecfg_tx_enable      (ecfg_tx_enable),
      .ecfg_tx_mmu_enable  (ecfg_tx_mmu_enable),
      .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
      .ecfg_tx_tp_enable   (ecfg_tx_tp_enable),
      .ecfg_tx_ctrlmode    (ecfg_tx_ctrlmode),
      .ecfg_tx_ctrlmode_bp (ecfg_tx_ctrlmode_bp),
      .ecfg_dataout        (ecfg_dataout)
   );

   ecfg_rx i_rx (
      .mi_clk              (mi_clk),
      .reset               (reset),
      .cfg_en              (cfg_en),
      .mi_we               (mi_we),
      .reg_idx             (reg_idx),
      .mi_din              (mi_din),
      .ecfg_rx_debug       (ecfg_rx_debug),
      .ecfg_datain         (ecfg_datain),
      .rx_dout             (rx_dout),
      .ecfg_rx_enable      (ecfg_rx_enable),
      .ecfg_rx_mmu_enable  (ecfg_rx_mmu_enable),
      .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
      .ecfg_rx_loopback    (ecfg_rx_loopback)
   );

endmodule

`default_nettype wire

//--- tests/ecfg_props.sv
/*
 bound assertions on the config register file top
 pin mode exclusion, mi_dout hold between reads, mi_dout clear after reset
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_props (
   input  wire                                     mi_clk,
   input  wire                                     reset,
   input  wire                                     mi_en,
   input  wire                                     mi_we,
   input  wire  [ecfg_regmap_pkg::MI_AW-1:0]       mi_addr,
   input  wire  [ecfg_regmap_pkg::MI_DW-1:0]       mi_dout,
   input  wire                                     ecfg_tx_gpio_enable,
   input  wire                                     ecfg_tx_tp_enable,
   input  wire                                     ecfg_rx_gpio_enable,
   input  wire                                     ecfg_rx_loopback
);
   import ecfg_regmap_pkg::*;

   int   assert_fails = 0;                    // read back by the testbench at the end
   logic read_strobe;

   // only a read inside the config page reloads the group douts
   assign read_strobe = mi_en && !mi_we && (mi_addr[MI_AW-1:PAGE_LSB] == ECFG_PAGE);

   // ##############################
   // pin mode decode
   // ##############################
   tx_modes_exclusive: assert property (@(posedge mi_clk) disable iff (reset)
      !(ecfg_tx_gpio_enable && ecfg_tx_tp_enable))
      else begin
         assert_fails++;
         $error("tx gpio and test pattern enables high together");
      end

   rx_modes_exclusive: assert property (@(posedge mi_clk) disable iff (reset)
      !(ecfg_rx_gpio_enable && ecfg_rx_loopback))
      else begin
         assert_fails++;
         $error("rx gpio and loopback enables high together");
      end

   // ##############################
   // read bus
   // ##############################
   dout_holds: assert property (@(posedge mi_clk) disable iff (reset)
      !read_strobe |=> $stable(mi_dout))
      else begin
         assert_fails++;
         $error("mi_dout moved without a read strobe");
      end

   dout_clear_after_reset: assert property (@(posedge mi_clk)
      reset |=> (mi_dout == '0))
      else begin
         assert_fails++;
         $error("mi_dout not zero after reset");
      end

endmodule

bind ecfg_elink ecfg_props i_props (
   .mi_clk              (mi_clk),
   .reset               (reset),
   .mi_en               (mi_en),
   .mi_we               (mi_we),
   .mi_addr             (mi_addr),
   .mi_dout             (mi_dout),
   .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
   .ecfg_tx_tp_enable   (ecfg_tx_tp_enable),
   .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
   .ecfg_rx_loopback    (ecfg_rx_loopback)
);

`default_nettype wire

//--- tests/ecfg_tb.sv
/*
 testbench for the config register file
 clock and reset, lfsr stimulus, register model, checker, cycle limit
*/
`timescale 1ns/1ns
`default_nettype none

module ecfg_tb;
   import ecfg_regmap_pkg::*;
   import elink_cfg_pkg::*;

   localparam int NUM_OPS       = 2000;
   localparam int MAX_OP_CYCLES = 4;                             // datain read may idle 3 first
   localparam int CYCLE_LIMIT   = NUM_OPS * MAX_OP_CYCLES + 2000;   // plus directed phases

   // dut inputs
   logic                mi_clk = 1'b0;
   logic                reset;
   logic                mi_en;
   logic                mi_we;
   logic [MI_AW-1:0]    mi_addr;
   logic [MI_DW-1:0]    mi_din;
   logic [DEBUG_W-1:0]  ecfg_tx_debug;
   logic [DEBUG_W-1:0]  ecfg_rx_debug;
   logic [PIN_W-1:0]    ecfg_datain;
   // dut outputs
   logic [MI_DW-1:0]    mi_dout;
   logic [COREID_W-1:0] ecfg_coreid;
   logic [CLKDIV_W-1:0] ecfg_clkdiv;
   logic                ecfg_sw_reset;
   logic                ecfg_tx_enable;
   logic                ecfg_tx_mmu_enable;
   logic                ecfg_tx_gpio_enable;
   logic                ecfg_tx_tp_enable;
   logic [CTRLMODE_W-1:0] ecfg_tx_ctrlmode;
   logic                ecfg_tx_ctrlmode_bp;
   logic [PIN_W-1:0]    ecfg_dataout;
   logic                ecfg_rx_enable;
   logic                ecfg_rx_mmu_enable;
   logic                ecfg_rx_gpio_enable;
   logic                ecfg_rx_loopback;

   // reference model state
   logic [COREID_W-1:0] m_coreid;
   logic [CLKDIV_W-1:0] m_clkdiv;
   logic                m_sw_reset;
   logic [8:0]          m_tx_reg;             // en, mmu, mode, ctrlmode, bp
   logic [PIN_W-1:0]    m_dataout;
   logic [3:0]          m_rx_reg;             // en, mmu, mode
   logic [2:0]          m_tx_sticky;
   logic [2:0]          m_rx_sticky;
   logic [MI_DW-1:0]    m_dout;               // last value loaded by a page read
   int                  datain_age;           // edges seen since pins last changed
   logic [15:0]         lfsr_state;
   int                  cycle_count = 0;

   always #20 mi_clk = ~mi_clk;               // 40 ns period

   ecfg_elink i_ecfg_elink (
      .mi_clk              (mi_clk),
      .reset               (reset),
      .mi_en               (mi_en),
      .mi_we               (mi_we),
      .mi_addr             (mi_addr),
      .mi_din              (mi_din),
      .mi_dout             (mi_dout),
      .ecfg_coreid         (ecfg_coreid),
      .ecfg_clkdiv         (ecfg_clkdiv),
      .ecfg_sw_reset       (ecfg_sw_reset),
      .ecfg_tx_debug       (ecfg_tx_debug),
      .ecfg_tx_enable      (ecfg_tx_enable),
      .ecfg_tx_mmu_enable  (ecfg_tx_mmu_enable),
      .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
      .ecfg_tx_tp_enable   (ecfg_tx_tp_enable),
      .ecfg_tx_ctrlmode    (ecfg_tx_ctrlmode),
      .ecfg_tx_ctrlmode_bp (ecfg_tx_ctrlmode_bp),
      .ecfg_dataout        (ecfg_dataout),
      .ecfg_rx_debug       (ecfg_rx_debug),
      .ecfg_datain         (ecfg_datain),
      .ecfg_rx_enable      (ecfg_rx_enable),
      .ecfg_rx_mmu_enable  (ecfg_rx_mmu_enable),
      .ecfg_rx_gpio_enable (ecfg_rx_gpio_enable),
      .ecfg_rx_loopback    (ecfg_rx_loopback)
   );

   // hard stop if the sequence stalls
   always @(posedge mi_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("run timed out after %0d cycles", cycle_count);
         $display("Checks failed");
         $fatal(1, "cycle limit reached");
      end
   end

   // ##############################
   // random source
   // ##############################
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // taps 16,14,13,11
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);   // one step per bit
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // page and index with random don't-care offset bits
   function automatic logic [MI_AW-1:0] addr_for(input logic [7:0] page, input logic [4:0] idx);
      logic [4:0] hi;
      logic [1:0] lo;
      hi = 5'(random_bits(5));
      lo = 2'(random_bits(2));
      return {page, hi, idx, lo};
   endfunction

   function automatic logic [15:0] random_debug();
      logic [2:0] sparse;
      sparse = 3'(random_bits(3) & random_bits(3) & random_bits(3));   // mostly low
      return {13'(random_bits(13)), sparse};
   endfunction

   // ##############################
   // reference model
   // ##############################
   task automatic model_reset();
      m_coreid    = 12'h808;
      m_clkdiv    = 4'd7;
      m_sw_reset  = 1'b0;
      m_tx_reg    = '0;
      m_dataout   = '0;
      m_rx_reg    = '0;
      m_tx_sticky = '0;
      m_rx_sticky = '0;
      m_dout      = '0;
      datain_age  = 0;
   endtask

   function automatic logic [31:0] model_read(input logic [4:0] idx);
      case (idx)
         EL_VERSION: return 32'h0000_0102;
         EL_COREID:  return {20'd0, m_coreid};
         EL_CLKDIV:  return {28'd0, m_clkdiv};
         EL_RESET:   return {31'd0, m_sw_reset};
         EL_TX:      return {23'd0, m_tx_reg};
         EL_DATAOUT: return {23'd0, m_dataout};
         EL_TXDEBUG: return {16'd0, ecfg_tx_debug[15:3], m_tx_sticky};   // live top
         EL_RX:      return {28'd0, m_rx_reg};
         EL_DATAIN:  return {23'd0, ecfg_datain};
         EL_RXDEBUG: return {16'd0, ecfg_rx_debug[15:3], m_rx_sticky};
         default:    return 32'd0;            // unmapped
      endcase
   endfunction

   task automatic model_write(input logic [4:0] idx, input logic [31:0] din);
      case (idx)
         EL_COREID:  m_coreid   = din[11:0];
         EL_CLKDIV:  m_clkdiv   = din[3:0];
         EL_RESET:   m_sw_reset = din[0];
         EL_TX:      m_tx_reg   = din[8:0];
         EL_DATAOUT: m_dataout  = din[8:0];
         EL_RX:      m_rx_reg   = din[3:0];
         default:    ;                        // read only or unmapped
      endcase
   endtask

   // ##############################
   // checking
   // ##############################
   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("Checks failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_outputs();
      check_value(32'(ecfg_coreid), 32'(m_coreid), "core id");
      check_value(32'(ecfg_clkdiv), 32'(m_clkdiv), "clock divider");
      check_value(32'(ecfg_sw_reset), 32'(m_sw_reset), "sw reset");
      check_value(32'(ecfg_tx_enable), 32'(m_tx_reg[0]), "tx enable");
      check_value(32'(ecfg_tx_mmu_enable), 32'(m_tx_reg[1]), "tx mmu enable");
      check_value(32'(ecfg_tx_gpio_enable), 32'(m_tx_reg[3:2] == MODE_GPIO), "tx gpio enable");
      check_value(32'(ecfg_tx_tp_enable), 32'(m_tx_reg[3:2] == MODE_TESTPAT), "tx tp enable");
      check_value(32'(ecfg_tx_ctrlmode), 32'(m_tx_reg[7:4]), "tx ctrlmode");
      check_value(32'(ecfg_tx_ctrlmode_bp), 32'(m_tx_reg[8]), "tx ctrlmode bypass");
      check_value(32'(ecfg_dataout), 32'(m_dataout), "data out");
      check_value(32'(ecfg_rx_enable), 32'(m_rx_reg[0]), "rx enable");
      check_value(32'(ecfg_rx_mmu_enable), 32'(m_rx_reg[1]), "rx mmu enable");
      check_value(32'(ecfg_rx_gpio_enable), 32'(m_rx_reg[3:2] == MODE_GPIO), "rx gpio enable");
      check_value(32'(ecfg_rx_loopback), 32'(m_rx_reg[3:2] == MODE_TESTPAT), "rx loopback");
   endtask

   // ##############################
   // bus access
   // ##############################
   // one strobe cycle between two falling edges
   task automatic run_cycle(input logic en, input logic we, input logic [MI_AW-1:0] addr,
                            input logic [31:0] din);
      logic       page_ok;
      logic [4:0] idx;
      page_ok = (addr[19:12] == 8'hF0);
      idx     = addr[6:2];
      mi_en   = en;
      mi_we   = we;
      mi_addr = addr;
      mi_din  = din;
      if (en && !we && page_ok) begin
         m_dout = model_read(idx);            // sticky value from before this edge
      end
      @(posedge mi_clk);
      if (en && we && page_ok) begin
         model_write(idx, din);
      end
      m_tx_sticky = m_tx_sticky | ecfg_tx_debug[2:0];
      m_rx_sticky = m_rx_sticky | ecfg_rx_debug[2:0];
      datain_age++;
      @(negedge mi_clk);
      mi_en = 1'b0;
      check_value(mi_dout, m_dout, "mi_dout");
      check_outputs();
   endtask

   task automatic idle_cycle();
      run_cycle(1'b0, 1'b0, '0, '0);
   endtask

   task automatic write_reg(input logic [4:0] idx, input logic [31:0] din);
      run_cycle(1'b1, 1'b1, addr_for(8'hF0, idx), din);
   endtask

   task automatic read_reg(input logic [4:0] idx);
      if (idx == EL_DATAIN) begin
         while (datain_age < 3) idle_cycle();   // let the synchronizer settle
      end
      run_cycle(1'b1, 1'b0, addr_for(8'hF0, idx), 32'd0);
   endtask

   task automatic drive_pins(input logic [PIN_W-1:0] value);
      ecfg_datain = value;
      datain_age  = 0;
   endtask

   // ##############################
   // test sequence
   // ##############################
   initial begin
      int         n;
      int         op;
      int         b;
      logic [4:0] idx;
      logic [7:0] page;
      logic       we_bit;

      lfsr_state    = 16'd50;
      reset         = 1'b1;
      mi_en         = 1'b0;
      mi_we         = 1'b0;
      mi_addr       = '0;
      mi_din        = '0;
      ecfg_tx_debug = '0;
      ecfg_rx_debug = '0;
      ecfg_datain   = '0;
      model_reset();
      repeat (2) @(posedge mi_clk);           // reset held two cycles
      @(negedge mi_clk);
      reset = 1'b0;
      check_value(mi_dout, 32'd0, "mi_dout after reset");
      check_outputs();

      // reset values over the whole index space
      for (n = 0; n < 32; n++) read_reg(5'(n));

      // pins held three cycles read back unchanged
      for (n = 0; n < 4; n++) begin
         drive_pins(9'(random_bits(9)));
         read_reg(EL_DATAIN);
      end

      // one pulse per sticky bit then a read after it drops
      for (b = 0; b < 3; b++) begin
         ecfg_tx_debug = {13'(random_bits(13)), 3'(1 << b)};
         ecfg_rx_debug = {13'(random_bits(13)), 3'(1 << b)};
         idle_cycle();
         ecfg_tx_debug[2:0] = 3'd0;
         ecfg_rx_debug[2:0] = 3'd0;
         read_reg(EL_TXDEBUG);
         read_reg(EL_RXDEBUG);
      end

      // off-page writes then off-page reads must not move anything
      for (n = 0; n < 16; n++) begin
         page = 8'(random_bits(8));
         if (page == 8'hF0) page = 8'h0F;
         run_cycle(1'b1, 1'b1, addr_for(page, 5'(n)), random_bits(32));
         run_cycle(1'b1, 1'b0, addr_for(page, 5'(n)), 32'd0);
      end

      // mixed random traffic
      for (n = 0; n < NUM_OPS; n++) begin
         op  = int'(random_bits(3));
         idx = 5'(random_bits(5));            // full index range including holes
         case (op)
            0, 1: write_reg(idx, random_bits(32));
            2, 3: read_reg(idx);
            4: begin
               page   = 8'(random_bits(8));
               we_bit = 1'(random_bits(1));
               if (page == 8'hF0) page = ~page;
               run_cycle(1'b1, we_bit, addr_for(page, idx), random_bits(32));
            end
            5: begin
               ecfg_tx_debug = random_debug();
               ecfg_rx_debug = random_debug();
               idle_cycle();
            end
            6: begin
               drive_pins(9'(random_bits(9)));
               idle_cycle();
            end
            default: read_reg(random_bits(1) != 0 ? EL_TXDEBUG : EL_RXDEBUG);
         endcase
      end

      idle_cycle();
      if (i_ecfg_elink.i_props.assert_fails != 0) begin
         $display("bound assertions failed %0d times", i_ecfg_elink.i_props.assert_fails);
         $display("Checks failed");
         $fatal(1, "assertion failures seen");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- files.f
design/ecfg_regmap_pkg.sv
design/elink_cfg_pkg.sv
design/ecfg_page_decode.sv
design/ecfg_base.sv
design/ecfg_tx.sv
design/ecfg_rx.sv
design/ecfg_elink.sv
tests/ecfg_props.sv
tests/ecfg_tb.sv
